//--- run_sim.sh
#!/bin/sh
# Build the performance monitor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_hpm \
   -f verilog.f -o tb_hpm_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_hpm_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "Finished with no errors"; then
   exit 0
fi
exit 1

//--- tests/hpm_asserts.sv
// --------------------------------------------------------------------------
// Credit and queue rules for the performance monitor, bound to hpm_top
// Reaches into the classifier and queue for the credit and occupancy counts
// Port widths follow the same fifo_depth sizing as the RTL
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module hpm_asserts
#(
   parameter int fifo_depth = 4
)
(
   input logic                                  clk,
   input logic                                  rst_n,
   input logic [$clog2(fifo_depth + 1)-1:0]     credits,
   input logic [$clog2(fifo_depth + 1)-1:0]     count,
   input logic                                  rec_valid,
   input logic                                  pop,
   input logic                                  head_valid
);

   localparam int cnt_width = $clog2(fifo_depth + 1);

   // Never more credits than queue slots
   a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
      credits <= cnt_width'(fifo_depth))
      else $error("credit count above queue depth");

   // Credits must keep the queue from overflowing
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      !(rec_valid && count == cnt_width'(fifo_depth)))
      else $error("push into a full event queue");

   a_pop_valid: assert property (@(posedge clk) disable iff (!rst_n)
      pop |-> head_valid)
      else $error("pop from an empty event queue");

   // Free credits, queued masks and the record in flight always sum to the depth
   // Any credit returned without a pop, or a pop without one, breaks the sum
   a_credit_pop: assert property (@(posedge clk) disable iff (!rst_n)
      int'(credits) + int'(count) + int'(rec_valid) == fifo_depth)
      else $error("credit return out of step with queue pops");

endmodule

bind hpm_top hpm_asserts #(.fifo_depth(fifo_depth)) i_asserts
(
   .clk        (clk),
   .rst_n      (rst_n),
   .credits    (i_classifier.credits),
   .count      (i_fifo.count),
   .rec_valid  (rec_valid),
   .pop        (pop),
   .head_valid (head_valid)
);

`default_nettype wire

//--- tests/tb_hpm.sv
// --------------------------------------------------------------------------
// Testbench for the performance monitor
// CSR state is changed only while busy is low, so the model applies
// selectors and inhibit bits at acceptance time
// Inputs change 2 ns after a rising edge and outputs are sampled at the falling edge
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_hpm
   import hpm_pkg::*;
();

   localparam int fifo_depth = 4;
   localparam int num_hpm    = 4;

   logic                      clk;
   logic                      rst_n;
   retire_s                   retire;
   csr_wr_s                   csr_wr;
   logic [csr_addr_width-1:0] csr_raddr;
   logic                      retire_ready;
   logic                      busy;
   logic [xlen-1:0]           csr_rdata;

   // Reference state
   logic [63:0] exp_minstret;
   logic [63:0] exp_hpm [num_hpm];
   int          exp_sel [num_hpm];
   logic [31:0] exp_inh;
   int          mismatches;
   int          failures;

   hpm_top #(.fifo_depth(fifo_depth), .num_hpm(num_hpm)) i_hpm_top
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .retire       (retire),
      .csr_wr       (csr_wr),
      .csr_raddr    (csr_raddr),
      .retire_ready (retire_ready),
      .busy         (busy),
      .csr_rdata    (csr_rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // Reference event mask built from the mask rules
   // ------------------------------------------------------------------------
   function automatic event_mask_t expected_mask(input retire_s r);
      event_mask_t m;
      m = '0;
      m[EV_RETIRED] = r.valid;
      m[EV_EXT_IRQ] = r.ext_irq;
      // Class k lines up with event bit k
      if (r.valid && r.ret_class != RC_NONE)
         m[int'(r.ret_class)] = 1'b1;
      if (r.valid && (r.ret_class inside {RC_BRANCH, RC_JAL, RC_JALR}))
         m[EV_ANY_JUMP] = 1'b1;
      if (r.exc)
      begin
         m[EV_INSTR_MISALIGNED] = (r.exc_cause == 4'd0);
         m[EV_ILLEGAL]          = (r.exc_cause == 4'd2);
         m[EV_ANY_MISALIGNED]   = (r.exc_cause inside {4'd0, 4'd4, 4'd6});
      end
      return m;
   endfunction

   function automatic retire_s random_record();
      retire_s r;
      r.valid     = ($urandom_range(7) != 0);
      r.ret_class = retire_class_e'(4'($urandom_range(13)));
      r.exc       = ($urandom_range(3) == 0);
      r.exc_cause = 4'($urandom_range(15));
      r.ext_irq   = ($urandom_range(3) == 0);
      // Keep every record acceptable
      if (!r.valid && !r.ext_irq)
         r.valid = 1'b1;
      return r;
   endfunction

   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act)
      begin
         mismatches++;
         $display("ERR %s expected 0x%0h actual 0x%0h", name, exp, act);
      end
   endtask

   // Counts an accepted record into the model
   task automatic model_accept(input retire_s r);
      event_mask_t m;
      m = expected_mask(r);
      if (!exp_inh[2])
         exp_minstret = exp_minstret + 64'(m[EV_RETIRED]);
      for (int n = 0; n < num_hpm; n++)
      begin
         if (!exp_inh[3+n] && exp_sel[n] < num_events)
            exp_hpm[n] = exp_hpm[n] + 64'(m[exp_sel[n]]);
      end
   endtask

   // Holds r on the bus until accepted or max_cycles edges pass
   task automatic try_send(input retire_s r, input int max_cycles, output bit accepted);
      bit ready;
      int cyc;
      accepted = 1'b0;
      cyc      = 0;
      retire   = r;
      while (!accepted && cyc < max_cycles)
      begin
         @(negedge clk);
         ready = retire_ready;
         @(posedge clk);
         #2;
         cyc++;
         if (ready)
         begin
            accepted = 1'b1;
            model_accept(r);
         end
      end
      if (accepted)
         retire = '0;
   endtask

   task automatic send_burst(input int num);
      bit acc;
      for (int i = 0; i < num; i++)
      begin
         try_send(random_record(), 100, acc);
         if (!acc)
         begin
            failures++;
            $display("Timeout: record %0d was not accepted within 100 cycles", i);
            retire = '0;
         end
      end
   endtask

   task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
      csr_wr = '{1'b1, addr, data};
      @(posedge clk);
      #2;
      csr_wr.wen = 1'b0;
   endtask

   task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
      csr_raddr = addr;
      @(negedge clk);
      data = csr_rdata;
      @(posedge clk);
      #2;
   endtask

   task automatic check_counter(input logic [11:0] lo, input logic [11:0] hi,
                                input string name, input logic [63:0] exp);
      logic [31:0] d;
      read_csr(lo, d);
      check({name, " low"}, 64'(exp[31:0]), 64'(d));
      read_csr(hi, d);
      check({name, " high"}, 64'(exp[63:32]), 64'(d));
   endtask

   // ------------------------------------------------------------------------
   // Compare process that waits for the pipeline to drain and reads every count
   // ------------------------------------------------------------------------
   task automatic compare_all();
      int cyc;
      logic [31:0] d;
      cyc = 0;
      while (busy && cyc < 200)
      begin
         @(posedge clk);
         #2;
         cyc++;
      end
      if (busy)
      begin
         failures++;
         $display("Timeout: busy stayed high for 200 cycles");
      end
      check_counter(addr_minstret, addr_minstreth, "minstret", exp_minstret);
      for (int n = 0; n < num_hpm; n++)
         check_counter(addr_mhpmcounter3 + 12'(n), addr_mhpmcounter3h + 12'(n),
                       $sformatf("mhpmcounter%0d", n + 3), exp_hpm[n]);
      read_csr(addr_mcountinhibit, d);
      check("mcountinhibit", 64'(exp_inh), 64'(d));
   endtask

   initial
   begin
      logic [31:0] rd_a;
      logic [31:0] rd_b;
      int          sel;
      int          accepted_cnt;
      bit          acc;
      bit          saw_low;
      retire_s     held;

      void'($urandom(81));
      mismatches   = 0;
      failures     = 0;
      exp_minstret = '0;
      exp_inh      = '0;
      for (int n = 0; n < num_hpm; n++)
      begin
         exp_hpm[n] = '0;
         exp_sel[n] = 0;
      end
      retire    = '0;
      csr_wr    = '0;
      csr_raddr = '0;
      rst_n     = 1'b0;
      repeat (2) @(posedge clk);
      #2;
      rst_n = 1'b1;

      // Reset values
      check("retire_ready", 64'd1, 64'(retire_ready));
      check("busy", 64'd0, 64'(busy));
      compare_all();
      read_csr(addr_mcycleh, rd_a);
      check("mcycleh", 64'd0, 64'(rd_a));
      for (int n = 0; n < num_hpm; n++)
      begin
         read_csr(addr_mhpmevent3 + 12'(n), rd_a);
         check($sformatf("mhpmevent%0d", n + 3), 64'd0, 64'(rd_a));
      end

      // Random selectors and a long random stream
      for (int n = 0; n < num_hpm; n++)
      begin
         sel = int'($urandom_range(num_events - 1));
         write_csr(addr_mhpmevent3 + 12'(n), 32'(sel));
         exp_sel[n] = sel;
      end
      send_burst(200);
      compare_all();

      // Inhibit minstret and mhpmcounter3
      write_csr(addr_mcountinhibit, 32'hC);
      exp_inh = 32'hC;
      send_burst(30);
      compare_all();

      // mcycle frozen and then running again
      write_csr(addr_mcountinhibit, 32'h1);
      exp_inh = 32'h1;
      read_csr(addr_mcycle, rd_a);
      repeat (3) @(posedge clk);
      #2;
      read_csr(addr_mcycle, rd_b);
      check("mcycle", 64'(rd_a), 64'(rd_b));
      write_csr(addr_mcountinhibit, 32'h0);
      exp_inh = 32'h0;
      read_csr(addr_mcycle, rd_a);
      repeat (3) @(posedge clk);
      #2;
      read_csr(addr_mcycle, rd_b);
      if (rd_b <= rd_a)
      begin
         failures++;
         $display("mcycle did not advance with counting enabled");
      end

      // Direct write to mhpmcounter4 with a carry into the high half afterwards
      write_csr(addr_mhpmevent3 + 12'd1, 32'(EV_RETIRED));
      exp_sel[1] = int'(EV_RETIRED);
      write_csr(addr_mhpmcounter3 + 12'd1, 32'hFFFF_FFF0);
      write_csr(addr_mhpmcounter3h + 12'd1, 32'h1234_5678);
      exp_hpm[1] = 64'h1234_5678_FFFF_FFF0;
      check_counter(addr_mhpmcounter3 + 12'd1, addr_mhpmcounter3h + 12'd1,
                    "mhpmcounter4", exp_hpm[1]);
      send_burst(30);
      compare_all();

      // A write every cycle stops the bank from draining
      csr_wr       = '{1'b1, addr_mcountinhibit, 32'h0};
      accepted_cnt = 0;
      saw_low      = 1'b0;
      held         = '0;
      while (!saw_low && accepted_cnt <= fifo_depth + 2)
      begin
         held = random_record();
         try_send(held, 1, acc);
         if (acc)
            accepted_cnt++;
         else
            saw_low = 1'b1;
      end
      if (!saw_low)
      begin
         failures++;
         $display("retire_ready did not fall under continuous CSR writes");
      end
      csr_wr.wen = 1'b0;
      if (saw_low)
      begin
         try_send(held, 100, acc);
         if (!acc)
         begin
            failures++;
            $display("Timeout: held record was not accepted after writes stopped");
            retire = '0;
         end
      end
      compare_all();

      // Out-of-range selector and unmapped addresses
      write_csr(addr_mhpmevent3, 32'd31);
      exp_sel[0] = 31;
      send_burst(20);
      compare_all();
      write_csr(12'h7C0, 32'hDEAD_BEEF);
      write_csr(12'hB07, 32'h0BAD_F00D);
      read_csr(12'h7C0, rd_a);
      check("csr 0x7c0", 64'd0, 64'(rd_a));
      read_csr(12'hB07, rd_a);
      check("csr 0xb07", 64'd0, 64'(rd_a));
      compare_all();

      $display("Value mismatches %0d, other failures %0d", mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
verilog/hpm_pkg.sv
verilog/retire_classifier.sv
verilog/event_fifo.sv
verilog/hpm_counter_bank.sv
verilog/hpm_top.sv
tests/hpm_asserts.sv
tests/tb_hpm.sv

//--- verilog/event_fifo.sv
// --------------------------------------------------------------------------
// Circular queue of event masks
// fifo_depth must be a power of two of 2 or more so pointers wrap freely
// There is no full flag since upstream credits keep pushes within capacity
// Head is visible the cycle after its push
// Push and pop may coincide
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module event_fifo
   import hpm_pkg::*;
#(
   parameter int fifo_depth = 4
)
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        rec_valid,
   input  event_mask_t rec_mask,
   input  logic        pop,
   output logic        head_valid,
   output event_mask_t head_mask
);

   localparam int ptr_width = $clog2(fifo_depth);
   localparam int cnt_bits  = $clog2(fifo_depth + 1);

   event_mask_t           mem [fifo_depth];
   logic [ptr_width-1:0]  wr_ptr;
   logic [ptr_width-1:0]  rd_ptr;
   logic [cnt_bits-1:0]   count;

   assign head_valid = (count != '0);
   assign head_mask  = mem[rd_ptr];

   // ------------------------------------------------------------------------
   // Pointers and occupancy
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (rec_valid)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         // Simultaneous push and pop leaves the count alone
         case ({rec_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Storage
   always_ff @(posedge clk)
   begin
      if (rec_valid)
         mem[wr_ptr] <= rec_mask;
   end

endmodule

`default_nettype wire

//--- verilog/hpm_counter_bank.sv
// --------------------------------------------------------------------------
// Counter bank with mcycle, minstret, mhpmcounter3 and up, and CSR access
// A CSR write cycle never pops, so writes and event counts cannot collide
// mcycle runs every edge unless inhibited and a write to it wins that edge
// Selector codes of num_events or more count nothing
// mcountinhibit bit 1 is hardwired to 0 and bits above 2+num_hpm read 0
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module hpm_counter_bank
   import hpm_pkg::*;
#(
   parameter int num_hpm = 4
)
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      head_valid,
   input  event_mask_t               head_mask,
   input  csr_wr_s                   csr_wr,
   input  logic [csr_addr_width-1:0] csr_raddr,
   output logic                      pop,
   output logic                      credit_return,
   output logic [xlen-1:0]           csr_rdata
);

   localparam int inh_width = 3 + num_hpm;

   logic [cnt_width-1:0] mcycle;
   logic [cnt_width-1:0] minstret;
   logic [cnt_width-1:0] hpm_cnt [num_hpm];
   hpm_event_e           hpm_sel [num_hpm];
   logic [inh_width-1:0] inhibit;
   logic [num_hpm-1:0]   hpm_hit;
   logic [num_hpm-1:0]   wr_cnt_lo;
   logic [num_hpm-1:0]   wr_cnt_hi;
   logic [num_hpm-1:0]   wr_sel;

   // Drain only when the CSR port is quiet and return one credit per pop
   assign pop           = head_valid & ~csr_wr.wen;
   assign credit_return = pop;

   // Per-counter event hit and write decode
   always_comb
   begin
      for (int n = 0; n < num_hpm; n++)
      begin
         hpm_hit[n]   = (hpm_sel[n] < num_events) ? head_mask[hpm_sel[n]] : 1'b0;
         wr_cnt_lo[n] = csr_wr.wen & (csr_wr.addr == addr_mhpmcounter3 + csr_addr_width'(n));
         wr_cnt_hi[n] = csr_wr.wen & (csr_wr.addr == addr_mhpmcounter3h + csr_addr_width'(n));
         wr_sel[n]    = csr_wr.wen & (csr_wr.addr == addr_mhpmevent3 + csr_addr_width'(n));
      end
   end

   // ------------------------------------------------------------------------
   // Counters, selectors and inhibit
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         mcycle   <= '0;
         minstret <= '0;
         inhibit  <= '0;
         for (int n = 0; n < num_hpm; n++)
         begin
            hpm_cnt[n] <= '0;
            hpm_sel[n] <= EV_NONE;
         end
      end
      else
      begin
         // Free-running cycle count where a write replaces one half
         if (csr_wr.wen && csr_wr.addr == addr_mcycle)
            mcycle[31:0] <= csr_wr.data;
         else if (csr_wr.wen && csr_wr.addr == addr_mcycleh)
            mcycle[63:32] <= csr_wr.data;
         else if (!inhibit[0])
            mcycle <= mcycle + 1'b1;

         if (csr_wr.wen)
         begin
            if (csr_wr.addr == addr_minstret)
               minstret[31:0] <= csr_wr.data;
            if (csr_wr.addr == addr_minstreth)
               minstret[63:32] <= csr_wr.data;
            // Bit 1 (time) is not implemented here
            if (csr_wr.addr == addr_mcountinhibit)
               inhibit <= csr_wr.data[inh_width-1:0] & ~inh_width'(2);
            for (int n = 0; n < num_hpm; n++)
            begin
               if (wr_cnt_lo[n])
                  hpm_cnt[n][31:0] <= csr_wr.data;
               if (wr_cnt_hi[n])
                  hpm_cnt[n][63:32] <= csr_wr.data;
               if (wr_sel[n])
                  hpm_sel[n] <= hpm_event_e'(csr_wr.data[4:0]);
            end
         end
         else if (pop)
         begin
            if (!inhibit[2])
               minstret <= minstret + cnt_width'(head_mask[EV_RETIRED]);
            for (int n = 0; n < num_hpm; n++)
            begin
               if (!inhibit[3+n])
                  hpm_cnt[n] <= hpm_cnt[n] + cnt_width'(hpm_hit[n]);
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // Read mux
   // ------------------------------------------------------------------------
   // Unmapped addresses return 0
   always_comb
   begin
      csr_rdata = '0;
      case (csr_raddr)
         addr_mcountinhibit: csr_rdata = xlen'(inhibit);
         addr_mcycle:        csr_rdata = mcycle[31:0];
         addr_mcycleh:       csr_rdata = mcycle[63:32];
         addr_minstret:      csr_rdata = minstret[31:0];
         addr_minstreth:     csr_rdata = minstret[63:32];
         default:            csr_rdata = '0;
      endcase
      for (int n = 0; n < num_hpm; n++)
      begin
         if (csr_raddr == addr_mhpmcounter3 + csr_addr_width'(n))
            csr_rdata = hpm_cnt[n][31:0];
         if (csr_raddr == addr_mhpmcounter3h + csr_addr_width'(n))
            csr_rdata = hpm_cnt[n][63:32];
         if (csr_raddr == addr_mhpmevent3 + csr_addr_width'(n))
            csr_rdata = xlen'(hpm_sel[n]);
      end
   end

endmodule

`default_nettype wire

//--- verilog/hpm_pkg.sv
// --------------------------------------------------------------------------
// Shared types and constants for the machine-mode performance monitor
// Event selector values double as bit positions in the event mask
// Class codes RC_LOAD..RC_UNKNOWN line up with EV_LOAD..EV_UNKNOWN
// Only mcycle, minstret and mhpmcounter3 and up are mapped
// --------------------------------------------------------------------------
`default_nettype none

package hpm_pkg;

   // Data path widths
   localparam int xlen           = 32;
   localparam int cnt_width      = 64;
   localparam int csr_addr_width = 12;
   localparam int num_hpm_max    = 4;
   localparam int num_events     = 20;

   // Instruction class of a retiring instruction
   typedef enum logic [3:0] {
      RC_NONE, RC_LOAD, RC_STORE, RC_CSR, RC_SYS, RC_ALU, RC_BRANCH,
      RC_JAL, RC_JALR, RC_MUL, RC_DIV, RC_REM, RC_HINT, RC_UNKNOWN
   } retire_class_e;

   // Event selector codes, also the mask bit index
   typedef enum logic [4:0] {
      EV_NONE             = 5'd0,
      EV_LOAD             = 5'd1,
      EV_STORE            = 5'd2,
      EV_CSR              = 5'd3,
      EV_SYS              = 5'd4,
      EV_ALU              = 5'd5,
      EV_BRANCH           = 5'd6,
      EV_JAL              = 5'd7,
      EV_JALR             = 5'd8,
      EV_MUL              = 5'd9,
      EV_DIV              = 5'd10,
      EV_REM              = 5'd11,
      EV_HINT             = 5'd12,
      EV_UNKNOWN          = 5'd13,
      EV_INSTR_MISALIGNED = 5'd14,
      EV_ILLEGAL          = 5'd15,
      EV_ANY_JUMP         = 5'd16,
      EV_ANY_MISALIGNED   = 5'd17,
      EV_RETIRED          = 5'd18,
      EV_EXT_IRQ          = 5'd19
   } hpm_event_e;

   typedef logic [num_events-1:0] event_mask_t;

   // One retirement record per cycle from the core
   typedef struct packed {
      logic          valid;
      retire_class_e ret_class;
      logic          exc;
      logic [3:0]    exc_cause;
      logic          ext_irq;
   } retire_s;

   // CSR write port
   typedef struct packed {
      logic                      wen;
      logic [csr_addr_width-1:0] addr;
      logic [xlen-1:0]           data;
   } csr_wr_s;

   // --------------------------------------------------------------------------
   // CSR map
   // --------------------------------------------------------------------------
   // Later counters and selectors sit at consecutive addresses
   localparam logic [csr_addr_width-1:0] addr_mcountinhibit = 12'h320;
   localparam logic [csr_addr_width-1:0] addr_mhpmevent3    = 12'h323;
   localparam logic [csr_addr_width-1:0] addr_mcycle        = 12'hB00;
   localparam logic [csr_addr_width-1:0] addr_minstret      = 12'hB02;
   localparam logic [csr_addr_width-1:0] addr_mhpmcounter3  = 12'hB03;
   localparam logic [csr_addr_width-1:0] addr_mcycleh       = 12'hB80;
   localparam logic [csr_addr_width-1:0] addr_minstreth     = 12'hB82;
   localparam logic [csr_addr_width-1:0] addr_mhpmcounter3h = 12'hB83;

endpackage

`default_nettype wire

//--- verilog/hpm_top.sv
// --------------------------------------------------------------------------
// Top of the performance monitor
// Data flows from classifier to event queue to counter bank
// fifo_depth must be a power of two of 2 or more
// num_hpm ranges from 1 to num_hpm_max
// Acceptance to counter update takes at least 3 edges
// busy low means every accepted record has been counted
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module hpm_top
   import hpm_pkg::*;
#(
   parameter int fifo_depth = 4,
   parameter int num_hpm    = 4
)
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  retire_s                   retire,
   input  csr_wr_s                   csr_wr,
   input  logic [csr_addr_width-1:0] csr_raddr,
   output logic                      retire_ready,
   output logic                      busy,
   output logic [xlen-1:0]           csr_rdata
);

   // Classifier to queue
   logic        rec_valid;
   event_mask_t rec_mask;

   // Queue to counter bank, and the credit path back
   logic        head_valid;
   event_mask_t head_mask;
   logic        pop;
   logic        credit_return;

   retire_classifier #(.fifo_depth(fifo_depth)) i_classifier
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .retire        (retire),
      .credit_return (credit_return),
      .retire_ready  (retire_ready),
      .busy          (busy),
      .rec_valid     (rec_valid),
      .rec_mask      (rec_mask)
   );

   event_fifo #(.fifo_depth(fifo_depth)) i_fifo
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .rec_valid  (rec_valid),
      .rec_mask   (rec_mask),
      .pop        (pop),
      .head_valid (head_valid),
      .head_mask  (head_mask)
   );

   hpm_counter_bank #(.num_hpm(num_hpm)) i_bank
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .head_valid    (head_valid),
      .head_mask     (head_mask),
      .csr_wr        (csr_wr),
      .csr_raddr     (csr_raddr),
      .pop           (pop),
      .credit_return (credit_return),
      .csr_rdata     (csr_rdata)
   );

endmodule

`default_nettype wire

//--- verilog/retire_classifier.sv
// --------------------------------------------------------------------------
// Retirement classifier and credit holder
// A record is taken when retire_ready is high and valid or ext_irq is set
// Starts with fifo_depth credits so the queue behind it never overflows
// Mask appears on rec_valid/rec_mask one edge after acceptance
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module retire_classifier
   import hpm_pkg::*;
#(
   parameter int fifo_depth = 4
)
(
   input  logic        clk,
   input  logic        rst_n,
   input  retire_s     retire,
   input  logic        credit_return,
   output logic        retire_ready,
   output logic        busy,
   output logic        rec_valid,
   output event_mask_t rec_mask
);

   localparam int cred_width = $clog2(fifo_depth + 1);

   logic [cred_width-1:0] credits;
   logic                  accept;
   event_mask_t           ev_mask;

   // Hold off the core once every queue slot is spoken for
   assign retire_ready = (credits != '0);
   assign accept       = retire_ready & (retire.valid | retire.ext_irq);

   // Anything spent and not yet returned is still on its way to a counter
   assign busy = (credits != cred_width'(fifo_depth)) | rec_valid;

   // ------------------------------------------------------------------------
   // Event mask
   // ------------------------------------------------------------------------
   always_comb
   begin
      ev_mask = '0;
      // Class codes share their index with the matching event bit
      if (retire.valid && retire.ret_class != RC_NONE && retire.ret_class <= RC_UNKNOWN)
         ev_mask[retire.ret_class] = 1'b1;
      ev_mask[EV_RETIRED]  = retire.valid;
      ev_mask[EV_ANY_JUMP] = retire.valid &
                             ((retire.ret_class == RC_BRANCH) ||
                              (retire.ret_class == RC_JAL) ||
                              (retire.ret_class == RC_JALR));
      // Cause 0 instr misaligned, 2 illegal, 4 load and 6 store misaligned
      ev_mask[EV_INSTR_MISALIGNED] = retire.exc & (retire.exc_cause == 4'd0);
      ev_mask[EV_ILLEGAL]          = retire.exc & (retire.exc_cause == 4'd2);
      ev_mask[EV_ANY_MISALIGNED]   = retire.exc & ((retire.exc_cause == 4'd0) ||
                                                   (retire.exc_cause == 4'd4) ||
                                                   (retire.exc_cause == 4'd6));
      ev_mask[EV_EXT_IRQ] = retire.ext_irq;
   end

   // Spend one credit per accepted record and regain one per return
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         credits   <= cred_width'(fifo_depth);
         rec_valid <= 1'b0;
      end
      else
      begin
         credits   <= credits + cred_width'(credit_return) - cred_width'(accept);
         rec_valid <= accept;
      end
   end

   // Outgoing mask is qualified by rec_valid
   always_ff @(posedge clk)
   begin
      if (accept)
         rec_mask <= ev_mask;
   end

endmodule

`default_nettype wire
